// ==== hdl/rtcPkg.sv ====
package rtcPkg;

    // Mode decision rate
    localparam int TickPeriod = 256;          // Clock cycles per tick

    // Chip time registers
    localparam logic [7:0] AddrSeconds      = 8'h21;
    localparam logic [7:0] AddrMinutes      = 8'h22;
    localparam logic [7:0] AddrHours        = 8'h23;

    // Countdown timer registers
    localparam logic [7:0] AddrTimerSeconds = 8'h41;
    localparam logic [7:0] AddrTimerMinutes = 8'h42;
    localparam logic [7:0] AddrTimerHours   = 8'h43;

    // Bus cycle shape
    localparam int PhaseCycles = 4;           // Address and data phase length
    localparam int GapCycles   = 2;           // Idle time with csN high

    localparam int CmdDepth    = 4;           // Both FIFOs

    typedef enum logic [1:0]
    {
        ModeWrite        = 2'b00,
        ModeRead         = 2'b01,
        ModeProgramTimer = 2'b10
    } rtcMode_t;

    // One register access on the chip bus
    typedef struct packed
    {
        logic       isWrite;
        logic [7:0] addr;
        logic [7:0] data;                     // Ignored for reads
    } rtcCmd_t;

    // Value read back from the chip
    typedef struct packed
    {
        logic [7:0] addr;
        logic [7:0] data;
    } rtcResult_t;

endpackage

// ==== hdl/modeSequencer.sv ====
module modeSequencer
(
    input  logic             clk,
    input  logic             Reset,
    input  logic             start,
    input  logic             write,
    input  logic             programTimer,
    input  logic [7:0]       setSeconds,
    input  logic [7:0]       setMinutes,
    input  logic [7:0]       setHours,
    input  logic [7:0]       timerSeconds,
    input  logic [7:0]       timerMinutes,
    input  logic [7:0]       timerHours,
    input  logic             cmdReady,
    output logic             cmdValid,
    output rtcPkg::rtcCmd_t  cmd,
    output rtcPkg::rtcMode_t mode,
    output logic             timerMode
);

    logic [$clog2(rtcPkg::TickPeriod)-1:0] tickCount;
    logic                                  tick;
    logic [1:0]                            burstIdx;   // Position within the burst
    rtcPkg::rtcMode_t                      nextMode;
    logic                                  startBurst;
    logic                                  accept;
    logic                                  advance;

    // Command for one slot of a burst, seconds first
    function automatic rtcPkg::rtcCmd_t buildCmd(input rtcPkg::rtcMode_t m,
                                                 input logic [1:0] idx);
        rtcPkg::rtcCmd_t c;
        logic            isTimer;
        isTimer   = (m == rtcPkg::ModeProgramTimer);
        c.isWrite = (m != rtcPkg::ModeRead);
        case (idx)
            2'd0:
            begin
                c.addr = isTimer ? rtcPkg::AddrTimerSeconds : rtcPkg::AddrSeconds;
                c.data = isTimer ? timerSeconds : setSeconds;
            end
            2'd1:
            begin
                c.addr = isTimer ? rtcPkg::AddrTimerMinutes : rtcPkg::AddrMinutes;
                c.data = isTimer ? timerMinutes : setMinutes;
            end
            default:
            begin
                c.addr = isTimer ? rtcPkg::AddrTimerHours : rtcPkg::AddrHours;
                c.data = isTimer ? timerHours : setHours;
            end
        endcase
        if (!c.isWrite)
            c.data = 8'h00;                   // Read carries no data
        return c;
    endfunction

    assign tick       = (tickCount == rtcPkg::TickPeriod - 1);
    assign startBurst = tick && !cmdValid;    // Tick skipped while burst pending
    assign accept     = cmdValid && cmdReady;
    assign advance    = accept && (burstIdx != 2'd2);
    assign timerMode  = (mode == rtcPkg::ModeProgramTimer);

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
            tickCount <= '0;
        else if (tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    always_comb
    begin
        nextMode = mode;
        if (start)
            nextMode = rtcPkg::ModeWrite;     // Start overrides everything
        else
        begin
            case (mode)
                rtcPkg::ModeWrite:
                    nextMode = write ? rtcPkg::ModeWrite : rtcPkg::ModeRead;
                rtcPkg::ModeRead:
                begin
                    if (write && !programTimer)
                        nextMode = rtcPkg::ModeWrite;
                    else if (programTimer && !write)
                        nextMode = rtcPkg::ModeProgramTimer;
                end
                default:
                    nextMode = rtcPkg::ModeRead;  // Timer load lasts one tick
            endcase
        end
    end

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
        begin
            mode     <= rtcPkg::ModeWrite;
            cmdValid <= 1'b0;
            burstIdx <= '0;
        end
        else if (startBurst)
        begin
            mode     <= nextMode;
            cmdValid <= 1'b1;
            burstIdx <= 2'd0;
        end
        else if (advance)
            burstIdx <= burstIdx + 2'd1;
        else if (accept)
            cmdValid <= 1'b0;                 // Third command taken
    end

    // Host values sampled when each command is loaded
    always_ff @(posedge clk)
    begin
        if (startBurst)
            cmd <= buildCmd(nextMode, 2'd0);
        else if (advance)
            cmd <= buildCmd(mode, burstIdx + 2'd1);
    end

    cmdHeld: assert property (@(posedge clk) disable iff (Reset)
        cmdValid && !cmdReady |=> cmdValid && $stable(cmd));

endmodule

// ==== hdl/cmdFifo.sv ====
module cmdFifo
#(
    parameter type payload_t = rtcPkg::rtcCmd_t,
    parameter int  Depth     = rtcPkg::CmdDepth
)
(
    input  logic     clk,
    input  logic     Reset,
    input  logic     inValid,
    input  payload_t inData,
    input  logic     outReady,
    output logic     inReady,
    output logic     outValid,
    output payload_t outData
);

    payload_t                     mem [Depth];
    logic [$clog2(Depth)-1:0]     wrPtr;
    logic [$clog2(Depth)-1:0]     rdPtr;
    logic [$clog2(Depth+1)-1:0]   count;      // Occupied slots
    logic                         push;
    logic                         pop;

    assign inReady  = (count != Depth);
    assign outValid = (count != 0);
    assign outData  = mem[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wrPtr] <= inData;
    end

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= (wrPtr == Depth - 1) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == Depth - 1) ? '0 : rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

    // A refused item stays offered so a full FIFO drops nothing
    heldWhileFull: assert property (@(posedge clk) disable iff (Reset)
        inValid && !inReady |=> inValid && $stable(inData));

    // Pointers meet only when the FIFO is empty or full
    pointersMatchCount: assert property (@(posedge clk) disable iff (Reset)
        (count == 0) || (count == Depth) |-> (rdPtr == wrPtr));

endmodule

// ==== hdl/rtcBusMaster.sv ====
module rtcBusMaster
(
    input  logic               clk,
    input  logic               Reset,
    input  logic               cmdValid,
    input  rtcPkg::rtcCmd_t    cmd,
    input  logic               resultReady,
    input  logic [7:0]         adIn,
    output logic               cmdReady,
    output logic               resultValid,
    output rtcPkg::rtcResult_t result,
    output logic               csN,
    output logic               aleHigh,
    output logic               rdN,
    output logic               wrN,
    output logic [7:0]         adOut,
    output logic               adOe
);

    typedef enum logic [1:0]
    {
        Idle,
        Address,
        Data,
        Gap
    } phase_t;

    phase_t                                 state;
    logic [$clog2(rtcPkg::PhaseCycles)-1:0] phaseCount;
    rtcPkg::rtcCmd_t                        cur;        // Command on the bus
    logic                                   phaseEnd;
    logic                                   lastGap;
    logic                                   slotFree;
    logic                                   pop;

    assign phaseEnd = (phaseCount == rtcPkg::PhaseCycles - 1);
    assign lastGap  = (state == Gap) && (phaseCount == rtcPkg::GapCycles - 1);
    assign slotFree = (state == Idle) || lastGap;           // Back-to-back pop in last gap cycle

    // A read waits for room in the result FIFO
    assign cmdReady = slotFree && (cmd.isWrite || resultReady);
    assign pop      = cmdValid && cmdReady;

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
        begin
            state      <= Idle;
            phaseCount <= '0;
        end
        else
        begin
            case (state)
                Idle:
                begin
                    if (pop)
                        state <= Address;
                    phaseCount <= '0;
                end
                Address:
                begin
                    if (phaseEnd)
                    begin
                        state      <= Data;
                        phaseCount <= '0;
                    end
                    else
                        phaseCount <= phaseCount + 1'b1;
                end
                Data:
                begin
                    if (phaseEnd)
                    begin
                        state      <= Gap;
                        phaseCount <= '0;
                    end
                    else
                        phaseCount <= phaseCount + 1'b1;
                end
                default:
                begin
                    if (lastGap)
                    begin
                        state      <= pop ? Address : Idle;
                        phaseCount <= '0;
                    end
                    else
                        phaseCount <= phaseCount + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            cur <= cmd;
        if (state == Data && phaseEnd)
        begin
            result.addr <= cur.addr;
            result.data <= adIn;                            // Sample on last data cycle
        end
    end

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
            resultValid <= 1'b0;
        else if (state == Data && phaseEnd && !cur.isWrite)
            resultValid <= 1'b1;                            // Pushed in first gap cycle
        else if (resultReady)
            resultValid <= 1'b0;
    end

    // Pin decode from the phase
    assign csN     = !(state == Address || state == Data);
    assign aleHigh = (state == Address);
    assign rdN     = !(state == Data && !cur.isWrite);
    assign wrN     = !(state == Data && cur.isWrite);
    assign adOe    = (state == Address) || (state == Data && cur.isWrite);
    assign adOut   = (state == Address) ? cur.addr : cur.data;  // Data held through gap

    // Each strobe lasts one data phase and never overlaps the other
    noStrobeOverlap: assert property (@(posedge clk) disable iff (Reset)
        $fell(rdN) || $fell(wrN) |-> (rdN != wrN) ##(rtcPkg::PhaseCycles) (rdN && wrN));

    // Room was checked at pop time, so the push never stalls
    resultNeverStalls: assert property (@(posedge clk) disable iff (Reset)
        resultValid |-> resultReady);

endmodule

// ==== hdl/rtcControl.sv ====
module rtcControl
(
    input  logic             clk,
    input  logic             Reset,
    input  logic             start,
    input  logic             write,
    input  logic             programTimer,
    input  logic [7:0]       setSeconds,
    input  logic [7:0]       setMinutes,
    input  logic [7:0]       setHours,
    input  logic [7:0]       timerSeconds,
    input  logic [7:0]       timerMinutes,
    input  logic [7:0]       timerHours,
    input  logic             readReady,
    input  logic [7:0]       adIn,
    output rtcPkg::rtcMode_t mode,
    output logic             timerMode,
    output logic             readValid,
    output logic [7:0]       readAddr,
    output logic [7:0]       readData,
    output logic             csN,
    output logic             aleHigh,
    output logic             rdN,
    output logic             wrN,
    output logic [7:0]       adOut,
    output logic             adOe
);

    logic               seqValid;
    logic               seqReady;
    rtcPkg::rtcCmd_t    seqCmd;
    logic               busValid;
    logic               busReady;
    rtcPkg::rtcCmd_t    busCmd;
    logic               resValid;
    logic               resReady;
    rtcPkg::rtcResult_t res;
    rtcPkg::rtcResult_t readOut;

    assign readAddr = readOut.addr;
    assign readData = readOut.data;

    modeSequencer i_modeSequencer
    (
        .clk(clk), .Reset(Reset),
        .start(start), .write(write), .programTimer(programTimer),
        .setSeconds(setSeconds), .setMinutes(setMinutes), .setHours(setHours),
        .timerSeconds(timerSeconds), .timerMinutes(timerMinutes), .timerHours(timerHours),
        .cmdReady(seqReady), .cmdValid(seqValid), .cmd(seqCmd),
        .mode(mode), .timerMode(timerMode)
    );

    cmdFifo #(.payload_t(rtcPkg::rtcCmd_t), .Depth(rtcPkg::CmdDepth)) i_cmdFifo
    (
        .clk(clk), .Reset(Reset),
        .inValid(seqValid), .inData(seqCmd), .inReady(seqReady),
        .outValid(busValid), .outData(busCmd), .outReady(busReady)
    );

    rtcBusMaster i_busMaster
    (
        .clk(clk), .Reset(Reset),
        .cmdValid(busValid), .cmd(busCmd), .cmdReady(busReady),
        .resultValid(resValid), .result(res), .resultReady(resReady),
        .csN(csN), .aleHigh(aleHigh), .rdN(rdN), .wrN(wrN),
        .adOut(adOut), .adOe(adOe), .adIn(adIn)
    );

    cmdFifo #(.payload_t(rtcPkg::rtcResult_t), .Depth(rtcPkg::CmdDepth)) i_resultFifo
    (
        .clk(clk), .Reset(Reset),
        .inValid(resValid), .inData(res), .inReady(resReady),
        .outValid(readValid), .outData(readOut), .outReady(readReady)
    );

endmodule

// ==== sim/rtcChipModel.sv ====
module rtcChipModel
(
    input  logic       clk,
    input  logic       csN,
    input  logic       aleHigh,
    input  logic       rdN,
    input  logic       wrN,
    input  logic [7:0] adOut,
    input  logic       adOe,
    output logic [7:0] adIn
);

    logic [7:0] regs [256];
    logic [7:0] addrLatch;

    initial
    begin
        for (int i = 0; i < 256; i++)
            regs[i] = 8'(i) ^ 8'h5A;          // Power-up contents differ per address
        addrLatch = 8'h00;
    end

    // Registers stay static unless the host writes them
    always @(posedge clk)
    begin
        if (!csN && aleHigh && adOe)
            addrLatch <= adOut;               // Address phase
        if (!csN && !wrN && adOe)
            regs[addrLatch] <= adOut;         // Write data phase
    end

    // Chip drives the bus only under a read strobe
    assign adIn = (!csN && !rdN && !adOe) ? regs[addrLatch] : 8'h00;

endmodule

// ==== sim/rtcControlTb.sv ====
module rtcControlTb;

    localparam int ClkPeriod = 40;
    localparam int StepWords = 16;            // Bytes per line of the input file
    localparam int MaxSteps  = 64;

    logic             clk = 1'b0;
    logic             Reset;
    logic             start;
    logic             write;
    logic             programTimer;
    logic [7:0]       setSeconds;
    logic [7:0]       setMinutes;
    logic [7:0]       setHours;
    logic [7:0]       timerSeconds;
    logic [7:0]       timerMinutes;
    logic [7:0]       timerHours;
    logic             readReady;
    logic [7:0]       adIn;
    rtcPkg::rtcMode_t mode;
    logic             timerMode;
    logic             readValid;
    logic [7:0]       readAddr;
    logic [7:0]       readData;
    logic             csN;
    logic             aleHigh;
    logic             rdN;
    logic             wrN;
    logic [7:0]       adOut;
    logic             adOe;

    logic [7:0]         stim [MaxSteps*StepWords];
    rtcPkg::rtcCmd_t    writeQ [$];           // Write cycles seen on the chip bus
    rtcPkg::rtcResult_t resultQ [$];          // Results taken by the host
    logic [7:0]         busAddr;
    logic [7:0]         busData;
    logic               monitorOn = 1'b0;
    longint             watchdogLimit = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 numSteps;
    int                 tickSum;

    rtcControl i_dut (.*);

    rtcChipModel i_chip (.*);

    always #(ClkPeriod/2) clk = ~clk;

    // Bus sampled mid-cycle where it is stable
    always @(negedge clk)
    begin
        if (aleHigh)
            busAddr = adOut;
        if (!wrN)
            busData = adOut;
        if (monitorOn && !rdN && !wrN)
        begin
            errors++;
            $display("Bus fault: rdN and wrN low together at time %0t", $time);
        end
    end

    always @(posedge wrN)
    begin
        if (monitorOn)
            writeQ.push_back(rtcPkg::rtcCmd_t'({1'b1, busAddr, busData}));
    end

    always @(posedge clk)
    begin
        if (monitorOn && readValid && readReady)
            resultQ.push_back(rtcPkg::rtcResult_t'({readAddr, readData}));
    end

    task automatic checkMode(input string name, input rtcPkg::rtcMode_t expected,
                             input rtcPkg::rtcMode_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error %s: expected mode %s, actual mode %s",
                     name, expected.name(), actual.name());
        end
    endtask

    task automatic checkResult(input string name, input rtcPkg::rtcResult_t expected,
                               input rtcPkg::rtcResult_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error %s: expected addr %h data %h, actual addr %h data %h",
                     name, expected.addr, expected.data, actual.addr, actual.data);
        end
    endtask

    task automatic checkWrite(input string name, input rtcPkg::rtcCmd_t expected,
                              input rtcPkg::rtcCmd_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error %s: expected write %h to %h, actual write %h to %h",
                     name, expected.data, expected.addr, actual.data, actual.addr);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic string testName(input logic [7:0] code);
        case (code)
            8'h01:   return "write";
            8'h02:   return "read";
            8'h03:   return "timer";
            8'h04:   return "transition";
            8'h05:   return "backpressure";
            default: return "unknown";
        endcase
    endfunction

    // Registers of a burst in order seconds, minutes, hours
    function automatic logic [7:0] expectedAddr(input rtcPkg::rtcMode_t m, input int idx);
        logic isTimer;
        isTimer = (m == rtcPkg::ModeProgramTimer);
        case (idx)
            0:       return isTimer ? rtcPkg::AddrTimerSeconds : rtcPkg::AddrSeconds;
            1:       return isTimer ? rtcPkg::AddrTimerMinutes : rtcPkg::AddrMinutes;
            default: return isTimer ? rtcPkg::AddrTimerHours : rtcPkg::AddrHours;
        endcase
    endfunction

    task automatic checkIdlePins(input string name);
        checkBit($sformatf("%s csN", name), 1'b1, csN);
        checkBit($sformatf("%s rdN", name), 1'b1, rdN);
        checkBit($sformatf("%s wrN", name), 1'b1, wrN);
        checkBit($sformatf("%s aleHigh", name), 1'b0, aleHigh);
        checkBit($sformatf("%s adOe", name), 1'b0, adOe);
        checkBit($sformatf("%s readValid", name), 1'b0, readValid);
        checkBit($sformatf("%s timerMode", name), 1'b0, timerMode);
        checkMode(name, rtcPkg::ModeWrite, mode);
    endtask

    task automatic loadSteps();
        int i;
        for (i = 0; i < MaxSteps * StepWords; i++)
            stim[i] = 8'hFF;                  // Unused lines read as end marker
        $readmemh("sim/rtcInput.txt", stim);
        numSteps = 0;
        tickSum  = 0;
        while (numSteps < MaxSteps && stim[numSteps * StepWords] != 8'hFF)
        begin
            tickSum += int'(stim[numSteps * StepWords + 10]);
            numSteps++;
        end
    endtask

    task automatic waitForItems(input string name, input int wantWrites, input int wantResults);
        int cycles;
        cycles = 0;
        while ((writeQ.size() < wantWrites || resultQ.size() < wantResults)
               && cycles < rtcPkg::TickPeriod)
        begin
            @(negedge clk);
            cycles++;
        end
        if (writeQ.size() < wantWrites || resultQ.size() < wantResults)
        begin
            errors++;
            $display("%s: timed out with %0d of %0d bus writes and %0d of %0d read results",
                     name, writeQ.size(), wantWrites, resultQ.size(), wantResults);
        end
    endtask

    task automatic runStep(input int step);
        int                 base;
        int                 ticks;
        int                 count;
        int                 i;
        string              name;
        rtcPkg::rtcMode_t   expMode;
        logic               isRead;
        logic               randomReady;
        logic [7:0]         expValue;
        rtcPkg::rtcCmd_t    extraWrite;
        rtcPkg::rtcResult_t extraResult;
        base         = step * StepWords;
        name         = $sformatf("%s step %0d", testName(stim[base]), step + 1);
        ticks        = int'(stim[base + 10]);
        expMode      = rtcPkg::rtcMode_t'(stim[base + 11][1:0]);
        randomReady  = stim[base + 15][0];
        isRead       = (expMode == rtcPkg::ModeRead);
        count        = 3 * ticks;
        start        = stim[base + 1][0];
        write        = stim[base + 2][0];
        programTimer = stim[base + 3][0];
        setSeconds   = stim[base + 4];
        setMinutes   = stim[base + 5];
        setHours     = stim[base + 6];
        timerSeconds = stim[base + 7];
        timerMinutes = stim[base + 8];
        timerHours   = stim[base + 9];
        repeat (ticks * rtcPkg::TickPeriod)
        begin
            @(negedge clk);
            // Rare host pops let results pile up and fill both FIFOs
            readReady = randomReady ? ($urandom_range(127, 0) == 0) : 1'b1;
        end
        readReady = 1'b1;
        checkMode(name, expMode, mode);
        checkBit($sformatf("%s timerMode", name), expMode == rtcPkg::ModeProgramTimer,
                 timerMode);
        waitForItems(name, isRead ? 0 : count, isRead ? count : 0);
        for (i = 0; i < count; i++)
        begin
            expValue = stim[base + 12 + (i % 3)];
            if (isRead && resultQ.size() > 0)
                checkResult(name, {expectedAddr(expMode, i % 3), expValue},
                            resultQ.pop_front());
            else if (!isRead && writeQ.size() > 0)
                checkWrite(name, {1'b1, expectedAddr(expMode, i % 3), expValue},
                           writeQ.pop_front());
        end
        while (writeQ.size() > 0)
        begin
            extraWrite = writeQ.pop_front();
            errors++;
            $display("%s: unexpected bus write of %h to address %h",
                     name, extraWrite.data, extraWrite.addr);
        end
        while (resultQ.size() > 0)
        begin
            extraResult = resultQ.pop_front();
            errors++;
            $display("%s: unexpected read result %h from address %h",
                     name, extraResult.data, extraResult.addr);
        end
    endtask

    initial
    begin
        Reset        = 1'b1;
        start        = 1'b0;
        write        = 1'b0;
        programTimer = 1'b0;
        setSeconds   = 8'h00;
        setMinutes   = 8'h00;
        setHours     = 8'h00;
        timerSeconds = 8'h00;
        timerMinutes = 8'h00;
        timerHours   = 8'h00;
        readReady    = 1'b1;
        void'($urandom(32'h820f));
        loadSteps();
        watchdogLimit = longint'(tickSum) * rtcPkg::TickPeriod * 2 * ClkPeriod
                        + 4 * rtcPkg::TickPeriod * ClkPeriod;
        if (numSteps == 0)
        begin
            errors++;
            $display("No test steps were read from sim/rtcInput.txt");
        end
        repeat (2) @(negedge clk);
        checkIdlePins("reset active");
        repeat (3) @(negedge clk);
        Reset     = 1'b0;
        monitorOn = 1'b1;
        @(negedge clk);
        checkIdlePins("reset released");
        repeat (rtcPkg::TickPeriod / 2 - 1) @(negedge clk);  // Steps start between ticks
        for (int s = 0; s < numSteps; s++)
            runStep(s);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        wait (watchdogLimit != 0);
        #(watchdogLimit);
        $display("Watchdog expired at time %0t before all steps finished", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== rtcControl.f ====
hdl/rtcPkg.sv
hdl/modeSequencer.sv
hdl/cmdFifo.sv
hdl/rtcBusMaster.sv
hdl/rtcControl.sv
sim/rtcChipModel.sv
sim/rtcControlTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rtcControlTb
FILELIST  = rtcControl.f
BUILD     = obj_dir
PASS_TEXT = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Output goes to the console and is searched for the pass line
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)

// ==== sim/rtcInput.txt ====
// code start write timer setS setM setH tmrS tmrM tmrH ticks mode exp0 exp1 exp2 randReady
// code 01 write 02 read 03 timer 04 transition 05 backpressure; mode 0 write 1 read 2 timer
01 01 00 00 30 45 12 05 10 01 02 00 30 45 12 00
02 00 00 00 30 45 12 05 10 01 01 01 30 45 12 00
02 00 00 00 30 45 12 05 10 01 02 01 30 45 12 00
03 00 00 01 30 45 12 05 10 01 01 02 05 10 01 00
03 00 00 00 30 45 12 05 10 01 01 01 30 45 12 00
04 00 00 00 30 45 12 05 10 01 01 01 30 45 12 00
04 00 01 01 30 45 12 05 10 01 01 01 30 45 12 00
04 00 00 01 30 45 12 05 10 01 01 02 05 10 01 00
04 00 00 00 30 45 12 05 10 01 01 01 30 45 12 00
04 00 01 00 31 46 13 05 10 01 01 00 31 46 13 00
04 00 01 00 32 47 14 05 10 01 01 00 32 47 14 00
04 00 01 01 33 48 15 05 10 01 01 00 33 48 15 00
04 01 00 00 34 49 16 05 10 01 01 00 34 49 16 00
04 01 00 01 35 50 17 05 10 01 01 00 35 50 17 00
04 01 01 00 36 51 18 05 10 01 01 00 36 51 18 00
04 01 01 01 37 52 19 05 10 01 01 00 37 52 19 00
04 00 00 01 37 52 19 05 10 01 01 01 37 52 19 00
04 01 00 00 40 53 20 05 10 01 01 00 40 53 20 00
04 00 00 00 40 53 20 05 10 01 01 01 40 53 20 00
04 01 00 01 41 54 21 05 10 01 01 00 41 54 21 00
04 00 00 00 41 54 21 05 10 01 01 01 41 54 21 00
04 01 01 00 42 55 22 05 10 01 01 00 42 55 22 00
04 00 00 00 42 55 22 05 10 01 01 01 42 55 22 00
04 01 01 01 43 56 23 05 10 01 01 00 43 56 23 00
04 00 00 00 43 56 23 05 10 01 01 01 43 56 23 00
04 00 00 01 43 56 23 06 11 02 01 02 06 11 02 00
04 00 00 01 43 56 23 06 11 02 01 01 43 56 23 00
04 00 00 01 43 56 23 06 11 02 01 02 06 11 02 00
04 00 01 00 43 56 23 06 11 02 01 01 43 56 23 00
04 00 00 01 43 56 23 06 11 02 01 02 06 11 02 00
04 00 01 01 43 56 23 06 11 02 01 01 43 56 23 00
04 00 00 01 43 56 23 06 11 02 01 02 06 11 02 00
04 01 00 00 44 57 08 06 11 02 01 00 44 57 08 00
04 00 00 00 44 57 08 06 11 02 01 01 44 57 08 00
04 00 00 01 44 57 08 06 11 02 01 02 06 11 02 00
04 01 00 01 45 58 09 06 11 02 01 00 45 58 09 00
04 00 00 00 45 58 09 06 11 02 01 01 45 58 09 00
04 00 00 01 45 58 09 06 11 02 01 02 06 11 02 00
04 01 01 00 46 59 10 06 11 02 01 00 46 59 10 00
04 00 00 00 46 59 10 06 11 02 01 01 46 59 10 00
04 00 00 01 46 59 10 06 11 02 01 02 06 11 02 00
04 01 01 01 47 00 11 06 11 02 01 00 47 00 11 00
04 00 00 00 47 00 11 06 11 02 01 01 47 00 11 00
05 00 00 00 47 00 11 06 11 02 03 01 47 00 11 01
FF // End marker
